/* Bender.yml */
package:
  name: router_output_port

dependencies: {}

sources:
  - files:
      - rtl/nocPkg.sv
      - rtl/portTimer.sv
      - rtl/switchArbiter.sv
      - rtl/outputLink.sv
      - rtl/routerOutputPort.sv
  - target: simulation
    files:
      - tb/routerOutputPortTb.sv

/* build.f */
rtl/nocPkg.sv
rtl/portTimer.sv
rtl/switchArbiter.sv
rtl/outputLink.sv
rtl/routerOutputPort.sv
tb/routerOutputPortTb.sv

/* rtl/nocPkg.sv */
package nocPkg;

  localparam int numPorts     = 5;
  localparam int flitIdWidth  = 3;
  localparam int payloadWidth = 16;
  localparam int lengthWidth  = 12;
  localparam int portIdxWidth = 3;
  localparam int stateWidth   = numPorts + 1; // Idle plus one bit per port.

  // Flit id codes.
  localparam logic [flitIdWidth-1:0] flitIdle = 3'd0;
  localparam logic [flitIdWidth-1:0] flitHead = 3'd1;
  localparam logic [flitIdWidth-1:0] flitBody = 3'd2;
  localparam logic [flitIdWidth-1:0] flitTail = 3'd3;

  // Port indices and bit positions in the per-port arrays.
  localparam logic [portIdxWidth-1:0] portL = 3'd0;
  localparam logic [portIdxWidth-1:0] portN = 3'd1;
  localparam logic [portIdxWidth-1:0] portE = 3'd2;
  localparam logic [portIdxWidth-1:0] portW = 3'd3;
  localparam logic [portIdxWidth-1:0] portS = 3'd4;

  // One-hot arbiter states.
  localparam logic [stateWidth-1:0] stIdle = 6'b000001;
  localparam logic [stateWidth-1:0] stL    = 6'b000010;
  localparam logic [stateWidth-1:0] stN    = 6'b000100;
  localparam logic [stateWidth-1:0] stE    = 6'b001000;
  localparam logic [stateWidth-1:0] stW    = 6'b010000;
  localparam logic [stateWidth-1:0] stS    = 6'b100000;

  // Header flits carry the grant quantum in the low bits.
  typedef union packed {
    struct packed {
      logic [payloadWidth-lengthWidth-1:0] rsvd;
      logic [lengthWidth-1:0]              length;
    } head;
    logic [payloadWidth-1:0] data;
  } flitPayload_t;

endpackage

/* rtl/outputLink.sv */
`timescale 1ns/1ps

module outputLink import nocPkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [numPorts-1:0]                   grant,
  input  logic [numPorts-1:0][flitIdWidth-1:0]  flitId,
  input  logic [numPorts-1:0][payloadWidth-1:0] flitData,
  output logic                                  outValid,
  output logic [flitIdWidth-1:0]                outId,
  output logic [payloadWidth-1:0]               outData,
  output logic [portIdxWidth-1:0]               outPort
);

  logic [flitIdWidth-1:0]  selId;
  flitPayload_t            selPayload;
  logic [portIdxWidth-1:0] selPort;

  // One-hot AND-OR mux over the per-port flits.
  always_comb
  begin
    selId           = '0;
    selPayload.data = '0;
    selPort         = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i])
      begin
        selId           = selId | flitId[i];
        selPayload.data = selPayload.data | flitData[i];
        selPort         = selPort | portIdxWidth'(i); // Source index.
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= (|grant) && (selId != flitIdle);
  end

  always_ff @(posedge clk)
  begin
    outId   <= selId;
    outData <= selPayload.data;
    outPort <= selPort;
  end

endmodule

/* rtl/portTimer.sv */
`timescale 1ns/1ps

module portTimer import nocPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [flitIdWidth-1:0] flitId,
  input  logic [lengthWidth-1:0] length,
  input  logic                   runTimer,
  output logic                   timesUp
);

  logic [lengthWidth-1:0] limit;
  logic [lengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == flitHead)
        limit <= length; // New quantum per packet.
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  // Quantum spent once the count reaches the header length.
  assign timesUp = (count == limit);

endmodule

/* rtl/routerOutputPort.sv */
`timescale 1ns/1ps

module routerOutputPort import nocPkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [numPorts-1:0][flitIdWidth-1:0]  flitId,
  input  logic [numPorts-1:0][payloadWidth-1:0] flitData,
  input  logic [numPorts-1:0]                   req,
  output logic [numPorts-1:0]                   grant,
  output logic                                  outValid,
  output logic [flitIdWidth-1:0]                outId,
  output logic [payloadWidth-1:0]               outData,
  output logic [portIdxWidth-1:0]               outPort
);

  // Switch allocation for the single output link.
  switchArbiter i_switchArbiter (
    .clk      (clk),
    .rst      (rst),
    .flitId   (flitId),
    .flitData (flitData),
    .req      (req),
    .grant    (grant)
  );

  // Registered crossbar slice that trails the grant by one cycle.
  outputLink i_outputLink (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .flitId   (flitId),
    .flitData (flitData),
    .outValid (outValid),
    .outId    (outId),
    .outData  (outData),
    .outPort  (outPort)
  );

endmodule

/* rtl/switchArbiter.sv */
`timescale 1ns/1ps

module switchArbiter import nocPkg::*;
(
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [numPorts-1:0][flitIdWidth-1:0]    flitId,
  input  logic [numPorts-1:0][payloadWidth-1:0]   flitData,
  input  logic [numPorts-1:0]                     req,
  output logic [numPorts-1:0]                     grant
);

  logic [stateWidth-1:0] state;
  logic [stateWidth-1:0] nextState;
  logic [numPorts-1:0]   runTimer;
  logic [numPorts-1:0]   timesUp;
  logic [numPorts-1:0]   stay;

  // First requester among span ports, starting at port start.
  function automatic logic [stateWidth-1:0] pickFrom(
    input int                  start,
    input int                  span,
    input logic [numPorts-1:0] reqs
  );
    logic [stateWidth-1:0] pick;
    logic                  found;
    int                    idx;
    pick  = stIdle;
    found = 1'b0;
    for (int k = 0; k < numPorts; k++)
    begin
      idx = (start + k) % numPorts;
      if (k < span && !found && reqs[idx])
      begin
        pick  = stateWidth'(1) << (idx + 1);
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  // Keep the current holder, else rotate past it.
  function automatic logic [stateWidth-1:0] holdOrPass(
    input int                  port,
    input logic [numPorts-1:0] stays,
    input logic [numPorts-1:0] reqs
  );
    if (stays[port])
      return stateWidth'(1) << (port + 1);
    return pickFrom(port + 1, numPorts - 1, reqs);
  endfunction

  for (genvar i = 0; i < numPorts; i++)
  begin : gTimer
    flitPayload_t hdr;

    assign hdr = flitData[i];

    portTimer i_portTimer (
      .clk      (clk),
      .rst      (rst),
      .flitId   (flitId[i]),
      .length   (hdr.head.length),
      .runTimer (runTimer[i]),
      .timesUp  (timesUp[i])
    );
  end

  assign stay = req & ~timesUp;

  always_comb
  begin
    case (state)
      stIdle:  nextState = pickFrom(portL, numPorts, req); // Fixed priority.
      stL:     nextState = holdOrPass(portL, stay, req);
      stN:     nextState = holdOrPass(portN, stay, req);
      stE:     nextState = holdOrPass(portE, stay, req);
      stW:     nextState = holdOrPass(portW, stay, req);
      stS:     nextState = holdOrPass(portS, stay, req);
      default: nextState = stIdle;
    endcase
  end

  // Only a continuing grant advances the holder's timer.
  always_comb
  begin
    runTimer = '0;
    if (nextState == state)
      runTimer = state[numPorts:1];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= stIdle;
    else
      state <= nextState;
  end

  assign grant = state[numPorts:1];

endmodule

/* tb/routerOutputPortTb.sv */
`timescale 1ns/1ps

module routerOutputPortTb import nocPkg::*; ();

  localparam int numRows   = 5;
  localparam int rowCycles = 400; // Per-row timeout in clock cycles.

  logic                                  clk = 1'b0;
  logic                                  rst;
  logic [numPorts-1:0][flitIdWidth-1:0]  flitId;
  logic [numPorts-1:0][payloadWidth-1:0] flitData;
  logic [numPorts-1:0]                   req;
  logic [numPorts-1:0]                   grant;
  logic                                  outValid;
  logic [flitIdWidth-1:0]                outId;
  logic [payloadWidth-1:0]               outData;
  logic [portIdxWidth-1:0]               outPort;

  // Scenario table. Packed per-port fields list S first, L last.
  string                                rowName  [numRows];
  logic [numPorts-1:0]                  rowMask  [numRows];
  logic [numPorts-1:0][lengthWidth-1:0] rowLen   [numRows];
  logic [numPorts-1:0][7:0]             rowFlits [numRows];
  int                                   rowDelay [numRows];
  string                                rowOrder [numRows];

  int                     srcSent  [numPorts];
  int                     srcTotal [numPorts];
  logic [lengthWidth-1:0] srcLen   [numPorts];
  logic [31:0]            lcgState = 32'h5465;

  int                      holder; // Model grant holder or -1 when idle.
  int                      held;
  logic                    expValid;
  logic [flitIdWidth-1:0]  expId;
  logic [payloadWidth-1:0] expData;
  logic [portIdxWidth-1:0] expPort;
  logic [numPorts-1:0]     lastGrant;
  int                      gotOrder [64];
  int                      gotCount;
  int                      delivered;
  int                      errorCount;
  int                      rowErrors;
  int                      testsRun;
  int                      testsFailed;
  logic                    timedOut;

  routerOutputPort i_routerOutputPort (
    .clk      (clk),
    .rst      (rst),
    .flitId   (flitId),
    .flitData (flitData),
    .req      (req),
    .grant    (grant),
    .outValid (outValid),
    .outId    (outId),
    .outData  (outData),
    .outPort  (outPort)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lcgStep(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic byte portLetter(input int p);
    case (p)
      0:       return "L";
      1:       return "N";
      2:       return "E";
      3:       return "W";
      default: return "S";
    endcase
  endfunction

  // Fixed priority from idle, otherwise hold for length plus one cycles, then rotate.
  function automatic int nextHolder(input int cur, input int curHeld,
                                    input logic [numPorts-1:0] r);
    int p;
    if (cur < 0)
    begin
      for (p = 0; p < numPorts; p++)
        if (r[p])
          return p;
      return -1;
    end
    if (r[cur] && curHeld <= srcLen[cur])
      return cur;
    for (int k = 1; k < numPorts; k++)
      if (r[(cur + k) % numPorts])
        return (cur + k) % numPorts;
    return -1;
  endfunction

  task automatic reportValue(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("Error at %0t: %s expected %0h, got %0h", $time, name, exp, got);
    errorCount++;
    rowErrors++;
  endtask

  task automatic presentFlit(input int p);
    flitPayload_t word;
    lcgState  = lcgStep(lcgState);
    word.data = lcgState[31:16];
    if (srcSent[p] >= srcTotal[p])
    begin
      flitId[p]   <= flitIdle; // Packet done.
      flitData[p] <= '0;
      req[p]      <= 1'b0;
    end
    else if (srcSent[p] == 0)
    begin
      word.head.length = srcLen[p]; // Reserved bits stay random.
      flitId[p]   <= flitHead;
      flitData[p] <= word.data;
      req[p]      <= 1'b1;
    end
    else
    begin
      flitId[p]   <= (srcSent[p] == srcTotal[p] - 1) ? flitTail : flitBody;
      flitData[p] <= word.data;
    end
  endtask

  // Check outputs at one clock edge, then advance the model and the sources.
  task automatic stepCycle();
    logic [numPorts-1:0] g;
    logic [numPorts-1:0] r;
    logic [numPorts-1:0] expGrant;
    int                  nxt;
    @(posedge clk);
    g        = grant;
    r        = req;
    expGrant = '0;
    if (holder >= 0)
      expGrant[holder] = 1'b1;
    if (g !== expGrant)
      reportValue("grant", expGrant, g);
    if (outValid !== expValid)
      reportValue("outValid", expValid, outValid);
    else if (expValid)
    begin
      if (outId !== expId)
        reportValue("outId", expId, outId);
      if (outData !== expData)
        reportValue("outData", expData, outData);
      if (outPort !== expPort)
        reportValue("outPort", expPort, outPort);
    end
    if (outValid === 1'b1)
      delivered++;
    if (g != '0 && g !== lastGrant && gotCount < 64)
    begin
      for (int k = 0; k < numPorts; k++)
        if (g[k])
          gotOrder[gotCount] = k;
      gotCount++;
    end
    lastGrant = g;
    expValid  = 1'b0; // Output register lags the grant by one cycle.
    if (holder >= 0)
    begin
      expValid = (flitId[holder] != flitIdle);
      expId    = flitId[holder];
      expData  = flitData[holder];
      expPort  = portIdxWidth'(holder);
    end
    nxt    = nextHolder(holder, held, r);
    held   = (nxt == holder) ? held + 1 : 1;
    holder = nxt;
    for (int p = 0; p < numPorts; p++)
      if (g[p] === 1'b1 && srcSent[p] < srcTotal[p])
      begin
        srcSent[p]++;
        presentFlit(p);
      end
  endtask

  task automatic fillTable();
    rowName[0]  = "single port";
    rowMask[0]  = 5'b00001;
    rowLen[0]   = {12'd0, 12'd0, 12'd0, 12'd0, 12'd2};
    rowFlits[0] = {8'd0, 8'd0, 8'd0, 8'd0, 8'd6};
    rowDelay[0] = 2;
    rowOrder[0] = "LL";
    rowName[1]  = "fixed priority";
    rowMask[1]  = 5'b11010;
    rowLen[1]   = {12'd10, 12'd10, 12'd0, 12'd10, 12'd0};
    rowFlits[1] = {8'd3, 8'd3, 8'd0, 8'd3, 8'd0};
    rowDelay[1] = 3;
    rowOrder[1] = "NWS";
    rowName[2]  = "rotation and quantum";
    rowMask[2]  = 5'b11111;
    rowLen[2]   = {12'd2, 12'd0, 12'd4, 12'd1, 12'd3};
    rowFlits[2] = {8'd8, 8'd8, 8'd8, 8'd8, 8'd8};
    rowDelay[2] = 2;
    rowOrder[2] = "LNEWSLN"; // Checked as a prefix.
    rowName[3]  = "early release";
    rowMask[3]  = 5'b10101;
    rowLen[3]   = {12'd6, 12'd0, 12'd1, 12'd0, 12'd5};
    rowFlits[3] = {8'd3, 8'd0, 8'd4, 8'd0, 8'd2};
    rowDelay[3] = 2;
    rowOrder[3] = "LESE";
    rowName[4]  = "east from idle";
    rowMask[4]  = 5'b00100;
    rowLen[4]   = {12'd0, 12'd0, 12'd1, 12'd0, 12'd0};
    rowFlits[4] = {8'd0, 8'd0, 8'd2, 8'd0, 8'd0};
    rowDelay[4] = 3;
    rowOrder[4] = "E";
  endtask

  task automatic runRow(input int r);
    int   cycles;
    int   want;
    logic busy;
    rowErrors = 0;
    delivered = 0;
    gotCount  = 0;
    want      = 0;
    for (int i = 0; i < rowDelay[r]; i++)
      stepCycle();
    for (int p = 0; p < numPorts; p++)
    begin
      srcSent[p]  = 0;
      srcTotal[p] = rowMask[r][p] ? int'(rowFlits[r][p]) : 0;
      srcLen[p]   = rowLen[r][p];
      want        = want + srcTotal[p];
      if (rowMask[r][p])
        presentFlit(p); // All sources raise req together.
    end
    cycles = 0;
    busy   = 1'b1;
    while (busy && cycles < rowCycles)
    begin
      stepCycle();
      cycles++;
      busy = (holder >= 0) || expValid;
      for (int p = 0; p < numPorts; p++)
        if (srcSent[p] < srcTotal[p])
          busy = 1'b1;
    end
    if (busy)
    begin
      $display("Timeout: test %s did not finish within %0d cycles", rowName[r], rowCycles);
      errorCount++;
      rowErrors++;
      timedOut = 1'b1;
    end
    if (delivered != want)
      reportValue("delivered flits", want, delivered);
    if (gotCount < rowOrder[r].len())
    begin
      $display("Test %s saw only %0d grants, expected the order %s", rowName[r], gotCount,
               rowOrder[r]);
      errorCount++;
      rowErrors++;
    end
    else
      for (int i = 0; i < rowOrder[r].len(); i++)
        if (portLetter(gotOrder[i]) != rowOrder[r].getc(i))
        begin
          $display("Error at %0t: grant order[%0d] expected %c, got %c", $time, i,
                   rowOrder[r].getc(i), portLetter(gotOrder[i]));
          errorCount++;
          rowErrors++;
        end
    testsRun++;
    if (rowErrors != 0)
      testsFailed++;
    $display("Test %0d %s: %s, %0d errors", r + 1, rowName[r],
             (rowErrors == 0) ? "ok" : "failed", rowErrors);
  endtask

  initial
  begin
    rst         = 1'b1;
    flitId      = '0;
    flitData    = '0;
    req         = '0;
    holder      = -1;
    held        = 0;
    expValid    = 1'b0;
    lastGrant   = '0;
    errorCount  = 0;
    rowErrors   = 0;
    testsRun    = 0;
    testsFailed = 0;
    timedOut    = 1'b0;
    for (int p = 0; p < numPorts; p++)
    begin
      srcSent[p]  = 0;
      srcTotal[p] = 0;
      srcLen[p]   = '0;
    end
    fillTable();
    for (int i = 0; i < 5; i++)
    begin
      @(posedge clk);
      if (i > 0 && grant !== '0)
        reportValue("grant", 0, grant);
      if (i > 0 && outValid !== 1'b0)
        reportValue("outValid", 0, outValid);
    end
    rst <= 1'b0;
    testsRun++;
    if (rowErrors != 0)
      testsFailed++;
    $display("Test 0 reset: %s, %0d errors", (rowErrors == 0) ? "ok" : "failed", rowErrors);
    for (int r = 0; r < numRows && !timedOut; r++)
      runRow(r);
    $display("Summary: %0d tests run, %0d failed, %0d errors", testsRun, testsFailed,
             errorCount);
    if (errorCount == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule
